// ==== project.f ====
logic/soc_pkg.sv
logic/reset_stretch.sv
logic/wb_region_decoder.sv
logic/csr_bridge.sv
logic/scratch_ram.sv
logic/sysctl_gpio.sv
logic/sys_timer.sv
logic/soc_top.sv
test/tb_soc.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

BUILD=build
LOG="$BUILD/sim.log"

if ! mkdir -p "$BUILD"; then
	echo "cannot create $BUILD"
	exit 1
fi

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_soc -Mdir "$BUILD" -o sim -f project.f; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD/sim" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "SIMULATION FAILED" "$LOG"; then
	exit 1
fi
if [ "$status" -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi
if ! grep -q "SIMULATION PASSED" "$LOG"; then
	echo "no result line in $LOG"
	exit 1
fi
exit 0

// ==== test/tb_soc.sv ====
// directed testbench for soc_top driven as one external Wishbone master
// outputs sampled on the falling edge and inputs changed on the rising edge
module tb_soc;
	timeunit 1ns;
	timeprecision 1ps;
	import soc_pkg::*;

	localparam int unsigned RST_HOLD  = 16;
	localparam int unsigned RAM_WORDS = 256;
	localparam logic [31:0] SYSTEM_ID = 32'h2A6B_19C4;
	localparam logic [31:0] SEED      = 32'hd97d_e3bd;

	// cycle bounds per test with timer compare at most 23
	localparam int unsigned XFER_BOUND  = 5;
	localparam int unsigned N_MAX       = 23;
	localparam int unsigned TEST_BOUND  = (RST_HOLD + 4) + 20 * XFER_BOUND + XFER_BOUND
		+ (10 * XFER_BOUND + 12) + (8 * XFER_BOUND + 3 * N_MAX + 12)
		+ (2 * (RST_HOLD + XFER_BOUND) + 6 * XFER_BOUND);
	localparam int unsigned TIMEOUT_CYCLES = 40 * TEST_BOUND;

	logic                  sys_clk = 1'b0;
	logic                  trigger_reset;
	wb_req_t               bus_req;
	wb_rsp_t               bus_rsp;
	logic [GPIO_IN_W-1:0]  gpio_i;
	logic [GPIO_OUT_W-1:0] gpio_o;
	irq_vec_t              irq;

	logic [31:0] lfsr_q;
	logic [31:0] exp_words [8];
	int unsigned cycle_cnt = 0;
	int unsigned errors;
	int unsigned checks;

	soc_top #(
		.RST_HOLD (RST_HOLD),
		.RAM_WORDS(RAM_WORDS),
		.SYSTEM_ID(SYSTEM_ID)
	) dut_i (
		.sys_clk      (sys_clk),
		.trigger_reset(trigger_reset),
		.wb_i         (bus_req),
		.gpio_i       (gpio_i),
		.wb_o         (bus_rsp),
		.gpio_o       (gpio_o),
		.irq_o        (irq)
	);

	// 100 ns period
	always #50 sys_clk = ~sys_clk;

	always @(posedge sys_clk)
		cycle_cnt <= cycle_cnt + 1;

	// ----------------------------------------------------------
	// helpers
	// ----------------------------------------------------------
	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one step per bit taken with the result in the low n bits
	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v      = {v[30:0], lfsr_q[31]};
			lfsr_q = lfsr_next(lfsr_q);
		end
	endtask

	// bank number in adr[15:12] and register word in adr[11:2]
	function automatic logic [31:0] csr_addr(logic [3:0] bank, logic [9:0] idx);
		return 32'h6000_0000 | {16'h0000, bank, idx, 2'b00};
	endfunction

	task automatic compare_word(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp);
			errors++;
		end
	endtask

	task automatic require(input logic cond, input string what);
		checks++;
		assert (cond === 1'b1) else begin
			$display("error: %s", what);
			errors++;
		end
	endtask

	// ----------------------------------------------------------
	// bus tasks
	// ----------------------------------------------------------
	// one classic cycle held until ack or err
	// cycles counts the sampling edges
	task automatic wb_xfer(input logic [31:0] adr, input logic we, input logic [31:0] dat,
		input logic [3:0] sel, output logic [31:0] rdat, output logic ack,
		output logic err, output int unsigned cycles);
		wb_req_t req;
		req     = '0;
		req.adr = adr;
		req.dat = dat;
		req.sel = sel;
		req.we  = we;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		cycles  = 0;
		@(posedge sys_clk);
		bus_req <= req;
		@(negedge sys_clk);
		while (bus_rsp.ack !== 1'b1 && bus_rsp.err !== 1'b1) begin
			@(posedge sys_clk);
			cycles++;
			@(negedge sys_clk);
		end
		rdat = bus_rsp.dat;
		ack  = bus_rsp.ack;
		err  = bus_rsp.err;
		@(posedge sys_clk);
		bus_req <= '0;
	endtask

	task automatic wb_write(input logic [31:0] adr, input logic [31:0] dat,
		input logic [3:0] sel = 4'hf);
		logic [31:0] rdat;
		logic        ack;
		logic        err;
		int unsigned cycles;
		wb_xfer(adr, 1'b1, dat, sel, rdat, ack, err, cycles);
		require(ack & ~err, $sformatf("write to 0x%08h was not acked", adr));
	endtask

	task automatic wb_read(input logic [31:0] adr, output logic [31:0] data,
		output int unsigned cycles);
		logic ack;
		logic err;
		wb_xfer(adr, 1'b0, 32'h0, 4'hf, data, ack, err, cycles);
		require(ack & ~err, $sformatf("read from 0x%08h was not acked", adr));
	endtask

	task automatic wb_expect_err(input logic [31:0] adr);
		logic [31:0] rdat;
		logic        ack;
		logic        err;
		int unsigned cycles;
		wb_xfer(adr, 1'b0, 32'h0, 4'hf, rdat, ack, err, cycles);
		require(err & ~ack, $sformatf("access to 0x%08h did not end in err alone", adr));
		require(cycles == 1, "err response did not come one cycle after the request");
		compare_word("wb_o.dat", rdat, 32'h0);
	endtask

	// counts sampled high cycles of one irq line
	// first_at is 1-based
	task automatic watch_irq(input logic timer_line, input int unsigned window,
		output int unsigned pulses, output int unsigned first_at);
		int unsigned c;
		pulses   = 0;
		first_at = 0;
		for (c = 1; c <= window; c++) begin
			@(posedge sys_clk);
			@(negedge sys_clk);
			if ((timer_line ? irq.timer : irq.gpio) === 1'b1) begin
				pulses++;
				if (first_at == 0)
					first_at = c;
			end
		end
	endtask

	// ----------------------------------------------------------
	// directed tests
	// ----------------------------------------------------------
	task automatic ram_test();
		logic [31:0] v;
		logic [31:0] got;
		logic [31:0] merged;
		logic [3:0]  sel;
		int unsigned cycles;
		for (int i = 0; i < 8; i++) begin
			rand_bits(32, v);
			exp_words[i] = v;
			wb_write(32'h40 + 32'(4 * i), v);
		end
		for (int i = 0; i < 8; i++) begin
			wb_read(32'h40 + 32'(4 * i), got, cycles);
			compare_word("wb_o.dat", got, exp_words[i]);
			require(cycles == 1, "RAM read did not ack one cycle after the request");
		end
		// partial byte lanes only, the expected word merged under sel
		rand_bits(4, v);
		sel = (v[3:0] == 4'h0 || v[3:0] == 4'hf) ? 4'h5 : v[3:0];
		rand_bits(32, v);
		merged = exp_words[2];
		for (int b = 0; b < 4; b++)
			if (sel[b])
				merged[8*b +: 8] = v[8*b +: 8];
		exp_words[2] = merged;
		wb_write(32'h48, v, sel);
		wb_read(32'h48, got, cycles);
		compare_word("wb_o.dat", got, merged);
		// bit 31 set still hits the same RAM word
		wb_read(32'h8000_0048, got, cycles);
		compare_word("wb_o.dat", got, merged);
	endtask

	task automatic unmapped_test();
		wb_expect_err(32'h3000_0010);
	endtask

	task automatic sysctl_test();
		logic [31:0] v;
		logic [31:0] got;
		logic [31:0] mask;
		int unsigned cycles;
		int unsigned pulses;
		int unsigned first_at;
		wb_read(csr_addr(CSR_BANK_SYSCTL, SYSCTL_REG_SYSTEM_ID), got, cycles);
		compare_word("system_id", got, SYSTEM_ID);
		require(cycles == 2, "CSR read did not ack two cycles after the request");
		rand_bits(GPIO_OUT_W, v);
		wb_write(csr_addr(CSR_BANK_SYSCTL, SYSCTL_REG_GPIO_OUT), v);
		@(negedge sys_clk);
		compare_word("gpio_o", 32'(gpio_o), v);
		wb_read(csr_addr(CSR_BANK_SYSCTL, SYSCTL_REG_GPIO_OUT), got, cycles);
		compare_word("gpio_out", got, v);
		// new input word with the read issued on the next edge
		rand_bits(32, v);
		@(posedge sys_clk);
		gpio_i <= v;
		wb_read(csr_addr(CSR_BANK_SYSCTL, SYSCTL_REG_GPIO_IN), got, cycles);
		compare_word("gpio_in", got, v);
		// masked bit toggles and gives one pulse
		rand_bits(5, v);
		mask = 32'd1 << v;
		wb_write(csr_addr(CSR_BANK_SYSCTL, SYSCTL_REG_IRQ_MASK), mask);
		@(posedge sys_clk);
		gpio_i <= gpio_i ^ mask;
		watch_irq(1'b0, 6, pulses, first_at);
		require(pulses == 1 && first_at <= 4, "masked gpio change gave no single irq pulse");
		// no pulse with the mask clear
		wb_write(csr_addr(CSR_BANK_SYSCTL, SYSCTL_REG_IRQ_MASK), 32'h0);
		@(posedge sys_clk);
		gpio_i <= gpio_i ^ mask;
		watch_irq(1'b0, 6, pulses, first_at);
		require(pulses == 0, "gpio irq fired with the mask clear");
	endtask

	task automatic timer_test();
		logic [31:0] v;
		logic [31:0] got;
		int unsigned n;
		int unsigned cycles;
		int unsigned pulses;
		int unsigned first_at;
		rand_bits(4, v);
		n = 8 + v;
		wb_write(csr_addr(CSR_BANK_TIMER, TIMER_REG_COMPARE), n);
		wb_write(csr_addr(CSR_BANK_TIMER, TIMER_REG_COUNTER), 32'h0);
		wb_write(csr_addr(CSR_BANK_TIMER, TIMER_REG_CONTROL), 32'h1);
		watch_irq(1'b1, n + 4, pulses, first_at);
		require(pulses == 1, "one-shot timer did not give exactly one irq pulse");
		// one-shot clears enable and autorestart stays 0
		wb_read(csr_addr(CSR_BANK_TIMER, TIMER_REG_CONTROL), got, cycles);
		compare_word("timer_control", got, 32'h0);
		wb_write(csr_addr(CSR_BANK_TIMER, TIMER_REG_COUNTER), 32'h0);
		wb_write(csr_addr(CSR_BANK_TIMER, TIMER_REG_CONTROL), 32'h3);
		watch_irq(1'b1, 2 * n + 8, pulses, first_at);
		require(pulses == 2, "autorestart timer did not give two irq pulses");
		wb_write(csr_addr(CSR_BANK_TIMER, TIMER_REG_CONTROL), 32'h0);
	endtask

	task automatic reset_test();
		logic [31:0] got;
		int unsigned cycles;
		// soft reset through the sysctl register
		wb_write(csr_addr(CSR_BANK_SYSCTL, SYSCTL_REG_GPIO_OUT), 32'hf);
		wb_write(csr_addr(CSR_BANK_SYSCTL, SYSCTL_REG_RESET), 32'h1);
		wb_read(32'h40, got, cycles);
		require(cycles >= RST_HOLD, "read acked before the soft reset hold ended");
		compare_word("wb_o.dat", got, exp_words[0]);
		@(negedge sys_clk);
		compare_word("gpio_o", 32'(gpio_o), 32'h0);
		// one-cycle pulse on the external pin
		wb_write(csr_addr(CSR_BANK_SYSCTL, SYSCTL_REG_GPIO_OUT), 32'h9);
		@(posedge sys_clk);
		trigger_reset <= 1'b1;
		@(posedge sys_clk);
		trigger_reset <= 1'b0;
		wb_read(32'h48, got, cycles);
		require(cycles >= RST_HOLD, "read acked before the trigger_reset hold ended");
		compare_word("wb_o.dat", got, exp_words[2]);
		@(negedge sys_clk);
		compare_word("gpio_o", 32'(gpio_o), 32'h0);
	endtask

	// ----------------------------------------------------------
	// main sequence and watchdog
	// ----------------------------------------------------------
	initial begin
		trigger_reset = 1'b1;
		bus_req       = '0;
		gpio_i        = '0;
		lfsr_q        = SEED;
		errors        = 0;
		checks        = 0;
		repeat (2) @(posedge sys_clk);
		trigger_reset <= 1'b0;
		// first access waits out the power-up hold
		ram_test();
		unmapped_test();
		sysctl_test();
		timer_test();
		reset_test();
		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		wait (cycle_cnt >= TIMEOUT_CYCLES);
		$display("error: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("checks run: %0d, errors: %0d", checks, errors);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== logic/soc_top.sv ====
// single external Wishbone master, RAM at region 0x0 and CSR banks at 0x6
// soc_rst is internal; trigger_reset or the soft reset register start it
module soc_top #(
	parameter int unsigned RST_HOLD  = 16,
	parameter int unsigned RAM_WORDS = 256,
	parameter logic [31:0] SYSTEM_ID = 32'h13004D31
) (
	input  logic                           sys_clk,
	input  logic                           trigger_reset,
	input  soc_pkg::wb_req_t               wb_i,
	input  logic [soc_pkg::GPIO_IN_W-1:0]  gpio_i,
	output soc_pkg::wb_rsp_t               wb_o,
	output logic [soc_pkg::GPIO_OUT_W-1:0] gpio_o,
	output soc_pkg::irq_vec_t              irq_o
);
	import soc_pkg::*;

	logic soc_rst;
	logic soft_reset;

	// slave side of the decoder
	wb_req_t ram_req;
	wb_req_t csr_req;
	wb_rsp_t ram_rsp;
	wb_rsp_t csr_rsp;

	// CSR bus, read words are ORed in the bridge
	csr_req_t    csr_bus;
	logic [31:0] csr_dr_sysctl;
	logic [31:0] csr_dr_timer;

	// ----------------------------------------------------------
	// reset
	// ----------------------------------------------------------
	reset_stretch #(.RST_HOLD(RST_HOLD)) rst_i (
		.sys_clk      (sys_clk),
		.trigger_reset(trigger_reset),
		.soft_reset_i (soft_reset),
		.soc_rst_o    (soc_rst)
	);

	// ----------------------------------------------------------
	// bus fabric
	// ----------------------------------------------------------
	wb_region_decoder dec_i (
		.sys_clk  (sys_clk),
		.soc_rst_i(soc_rst),
		.wb_i     (wb_i),
		.ram_rsp_i(ram_rsp),
		.csr_rsp_i(csr_rsp),
		.ram_req_o(ram_req),
		.csr_req_o(csr_req),
		.wb_o     (wb_o)
	);

	scratch_ram #(.RAM_WORDS(RAM_WORDS)) ram_i (
		.sys_clk  (sys_clk),
		.soc_rst_i(soc_rst),
		.wb_i     (ram_req),
		.wb_o     (ram_rsp)
	);

	csr_bridge brg_i (
		.sys_clk        (sys_clk),
		.soc_rst_i      (soc_rst),
		.wb_i           (csr_req),
		.csr_dr_sysctl_i(csr_dr_sysctl),
		.csr_dr_timer_i (csr_dr_timer),
		.wb_o           (csr_rsp),
		.csr_o          (csr_bus)
	);

	// ----------------------------------------------------------
	// CSR banks
	// ----------------------------------------------------------
	sysctl_gpio #(
		.SYSTEM_ID(SYSTEM_ID),
		.CSR_BANK (CSR_BANK_SYSCTL)
	) sysctl_i (
		.sys_clk     (sys_clk),
		.soc_rst_i   (soc_rst),
		.csr_i       (csr_bus),
		.gpio_i      (gpio_i),
		.csr_do_o    (csr_dr_sysctl),
		.gpio_o      (gpio_o),
		.irq_o       (irq_o.gpio),
		.soft_reset_o(soft_reset)
	);

	sys_timer #(.CSR_BANK(CSR_BANK_TIMER)) timer_i (
		.sys_clk  (sys_clk),
		.soc_rst_i(soc_rst),
		.csr_i    (csr_bus),
		.csr_do_o (csr_dr_timer),
		.irq_o    (irq_o.timer)
	);

endmodule

// ==== logic/sys_timer.sv ====
// compare timer CSR bank, counts sys_clk cycles while enabled
// a CSR write in the match cycle overrides the match update
module sys_timer #(
	parameter logic [3:0] CSR_BANK = soc_pkg::CSR_BANK_TIMER
) (
	input  logic              sys_clk,
	input  logic              soc_rst_i,
	input  soc_pkg::csr_req_t csr_i,
	output logic [31:0]       csr_do_o,
	output logic              irq_o
);
	import soc_pkg::*;

	// control bits
	logic        en_q;
	logic        autorestart_q;
	logic [31:0] compare_q;
	logic [31:0] counter_q;
	logic        irq_q;
	logic        hit;
	logic        wr;
	logic [9:0]  reg_idx;

	assign hit     = csr_hit(csr_i, CSR_BANK);
	assign wr      = hit & csr_i.we;
	assign reg_idx = csr_i.a[9:0];

	always_ff @(posedge sys_clk) begin
		if (soc_rst_i) begin
			en_q          <= 1'b0;
			autorestart_q <= 1'b0;
			compare_q     <= '0;
			counter_q     <= '0;
			irq_q         <= 1'b0;
		end else begin
			irq_q <= 1'b0;
			if (en_q) begin
				// match wraps to zero and fires
				if (counter_q == compare_q) begin
					counter_q <= '0;
					irq_q     <= 1'b1;
					if (!autorestart_q)
						en_q <= 1'b0;
				end else begin
					counter_q <= counter_q + 1'b1;
				end
			end
			// register writes last
			if (wr) begin
				case (reg_idx)
					TIMER_REG_CONTROL: begin
						en_q          <= csr_i.dw[0];
						autorestart_q <= csr_i.dw[1];
					end
					TIMER_REG_COMPARE: compare_q <= csr_i.dw;
					TIMER_REG_COUNTER: counter_q <= csr_i.dw;
					default: ;
				endcase
			end
		end
	end

	// ----------------------------------------------------------
	// read mux
	// ----------------------------------------------------------
	always_comb begin
		csr_do_o = '0;
		if (hit) begin
			case (reg_idx)
				TIMER_REG_CONTROL: csr_do_o = {30'd0, autorestart_q, en_q};
				TIMER_REG_COMPARE: csr_do_o = compare_q;
				TIMER_REG_COUNTER: csr_do_o = counter_q;
				default:           csr_do_o = '0;
			endcase
		end
	end

	assign irq_o = irq_q;

endmodule

// ==== logic/sysctl_gpio.sv ====
// system control CSR bank: GPIO, change interrupt, system ID, soft reset
// gpio_i is asynchronous and goes through two flops before use
module sysctl_gpio #(
	parameter logic [31:0] SYSTEM_ID = 32'h13004D31,
	parameter logic [3:0]  CSR_BANK  = soc_pkg::CSR_BANK_SYSCTL
) (
	input  logic                           sys_clk,
	input  logic                           soc_rst_i,
	input  soc_pkg::csr_req_t              csr_i,
	input  logic [soc_pkg::GPIO_IN_W-1:0]  gpio_i,
	output logic [31:0]                    csr_do_o,
	output logic [soc_pkg::GPIO_OUT_W-1:0] gpio_o,
	output logic                           irq_o,
	output logic                           soft_reset_o
);
	import soc_pkg::*;

	logic [GPIO_IN_W-1:0]  sync1_q, sync2_q, prev_q;
	logic [GPIO_IN_W-1:0]  mask_q;
	logic [GPIO_OUT_W-1:0] gpio_out_q;
	logic                  irq_q;
	logic                  soft_reset_q;
	logic                  hit;
	logic                  wr;
	logic [9:0]            reg_idx;

	assign hit     = csr_hit(csr_i, CSR_BANK);
	assign wr      = hit & csr_i.we;
	assign reg_idx = csr_i.a[9:0];

	// ----------------------------------------------------------
	// input synchroniser, prev_q for edge detect
	// ----------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		sync1_q <= gpio_i;
		sync2_q <= sync1_q;
		prev_q  <= sync2_q;
	end

	always_ff @(posedge sys_clk) begin
		if (soc_rst_i) begin
			gpio_out_q   <= '0;
			mask_q       <= '0;
			irq_q        <= 1'b0;
			soft_reset_q <= 1'b0;
		end else begin
			// any masked bit changed, either direction
			irq_q        <= |((sync2_q ^ prev_q) & mask_q);
			// one-cycle pulse, lands on the bridge ack cycle
			soft_reset_q <= wr && (reg_idx == SYSCTL_REG_RESET);
			if (wr) begin
				case (reg_idx)
					SYSCTL_REG_GPIO_OUT: gpio_out_q <= csr_i.dw[GPIO_OUT_W-1:0];
					SYSCTL_REG_IRQ_MASK: mask_q <= csr_i.dw[GPIO_IN_W-1:0];
					default: ;
				endcase
			end
		end
	end

	// read mux, zero when another bank is addressed
	always_comb begin
		csr_do_o = '0;
		if (hit) begin
			case (reg_idx)
				SYSCTL_REG_GPIO_IN:   csr_do_o = 32'(sync2_q);
				SYSCTL_REG_GPIO_OUT:  csr_do_o = 32'(gpio_out_q);
				SYSCTL_REG_IRQ_MASK:  csr_do_o = 32'(mask_q);
				SYSCTL_REG_SYSTEM_ID: csr_do_o = SYSTEM_ID;
				default:              csr_do_o = '0;
			endcase
		end
	end

	assign gpio_o       = gpio_out_q;
	assign irq_o        = irq_q;
	assign soft_reset_o = soft_reset_q;

endmodule

// ==== logic/scratch_ram.sv ====
// RAM_WORDS must be a power of two, addresses wrap modulo the size
// contents are kept across soc_rst
module scratch_ram #(
	parameter int unsigned RAM_WORDS = 256
) (
	input  logic             sys_clk,
	input  logic             soc_rst_i,
	input  soc_pkg::wb_req_t wb_i,
	output soc_pkg::wb_rsp_t wb_o
);
	import soc_pkg::*;

	localparam int AW = $clog2(RAM_WORDS);

	logic [31:0]   mem [RAM_WORDS];
	logic [AW-1:0] idx;
	logic          access;
	logic          ack_q;
	logic [31:0]   dat_q;

	// word index, upper address bits dropped
	assign idx = wb_i.adr[AW+1:2];

	// new transfer, not the ack cycle of the previous one
	assign access = wb_i.cyc & wb_i.stb & ~ack_q & ~soc_rst_i;

	always_ff @(posedge sys_clk) begin
		if (soc_rst_i)
			ack_q <= 1'b0;
		else
			ack_q <= access;
	end

	// byte lane writes, read is old data
	always_ff @(posedge sys_clk) begin
		if (access && wb_i.we) begin
			for (int b = 0; b < 4; b++) begin
				if (wb_i.sel[b])
					mem[idx][8*b +: 8] <= wb_i.dat[8*b +: 8];
			end
		end
		dat_q <= mem[idx];
	end

	assign wb_o.dat = dat_q;
	assign wb_o.ack = ack_q;
	assign wb_o.err = 1'b0;

endmodule

// ==== logic/csr_bridge.sv ====
// Wishbone to CSR bridge, ack two cycles after the request is captured
// sel is not used, CSR writes are always whole words
module csr_bridge (
	input  logic              sys_clk,
	input  logic              soc_rst_i,
	input  soc_pkg::wb_req_t  wb_i,
	input  logic [31:0]       csr_dr_sysctl_i,
	input  logic [31:0]       csr_dr_timer_i,
	output soc_pkg::wb_rsp_t  wb_o,
	output soc_pkg::csr_req_t csr_o
);
	import soc_pkg::*;

	bridge_state_e state_q;

	// captured request
	logic [13:0] a_q;
	logic        we_q;
	logic [31:0] dw_q;
	// read word returned to the master
	logic [31:0] dat_q;

	// ----------------------------------------------------------
	// FSM
	// ----------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (soc_rst_i) begin
			state_q <= BR_IDLE;
		end else begin
			case (state_q)
				BR_IDLE:    if (wb_i.cyc & wb_i.stb) state_q <= BR_ACCESS;
				BR_ACCESS:  state_q <= BR_RESPOND;
				// master drops stb while we sit here
				default:    state_q <= BR_IDLE;
			endcase
		end
	end

	// capture and read-back registers
	always_ff @(posedge sys_clk) begin
		if (state_q == BR_IDLE) begin
			// word aligned registers
			a_q  <= wb_i.adr[15:2];
			we_q <= wb_i.we;
			dw_q <= wb_i.dat;
		end
		// banks drive zero unless addressed
		if (state_q == BR_ACCESS)
			dat_q <= csr_dr_sysctl_i | csr_dr_timer_i;
	end

	// write strobe only in the access cycle
	assign csr_o.a  = a_q;
	assign csr_o.we = we_q & (state_q == BR_ACCESS);
	assign csr_o.dw = dw_q;

	assign wb_o.dat = dat_q;
	assign wb_o.ack = (state_q == BR_RESPOND);
	assign wb_o.err = 1'b0;

endmodule

// ==== logic/wb_region_decoder.sv ====
// one master, two slaves; address bit 31 is ignored
// unmapped regions answer with a single-cycle err and zero data
module wb_region_decoder (
	input  logic             sys_clk,
	input  logic             soc_rst_i,
	input  soc_pkg::wb_req_t wb_i,
	input  soc_pkg::wb_rsp_t ram_rsp_i,
	input  soc_pkg::wb_rsp_t csr_rsp_i,
	output soc_pkg::wb_req_t ram_req_o,
	output soc_pkg::wb_req_t csr_req_o,
	output soc_pkg::wb_rsp_t wb_o
);
	import soc_pkg::*;

	region_e region;
	logic    unmapped;
	logic    err_q;

	// region from adr[30:28]
	assign region   = region_e'(wb_i.adr[30:28]);
	assign unmapped = (region != REGION_RAM) && (region != REGION_CSR);

	// ----------------------------------------------------------
	// request steering
	// ----------------------------------------------------------
	always_comb begin
		// payload goes to both, only stb is steered
		ram_req_o     = wb_i;
		csr_req_o     = wb_i;
		ram_req_o.stb = wb_i.stb & (region == REGION_RAM);
		csr_req_o.stb = wb_i.stb & (region == REGION_CSR);
	end

	// error slave, one cycle late like the RAM
	always_ff @(posedge sys_clk) begin
		if (soc_rst_i)
			err_q <= 1'b0;
		else
			// ~err_q so a held strobe does not see a second err
			err_q <= wb_i.cyc & wb_i.stb & unmapped & ~err_q;
	end

	// ----------------------------------------------------------
	// response mux
	// ----------------------------------------------------------
	always_comb begin
		case (region)
			REGION_RAM: wb_o = ram_rsp_i;
			REGION_CSR: wb_o = csr_rsp_i;
			default: begin
				wb_o     = '0;
				wb_o.err = err_q;
			end
		endcase
	end

endmodule

// ==== logic/reset_stretch.sv ====
// holds soc_rst for RST_HOLD cycles after the last request
// relies on register initial values for the power-up reset
module reset_stretch #(
	parameter int unsigned RST_HOLD = 16
) (
	input  logic sys_clk,
	input  logic trigger_reset,
	input  logic soft_reset_i,
	output logic soc_rst_o
);
	localparam int CW = $clog2(RST_HOLD + 1);

	// power-up starts as if a request had just arrived
	logic [CW-1:0] count_q = CW'(RST_HOLD);
	logic          soc_rst_q = 1'b1;
	logic          req;

	// external pin or sysctl register write
	assign req = trigger_reset | soft_reset_i;

	always_ff @(posedge sys_clk) begin
		// any new request reloads the full hold time
		if (req)
			count_q <= CW'(RST_HOLD);
		else if (count_q != '0)
			count_q <= count_q - 1'b1;
		soc_rst_q <= req | (count_q != '0);
	end

	assign soc_rst_o = soc_rst_q;

endmodule

// ==== logic/soc_pkg.sv ====
// shared bus types, address map and CSR register indexes for the SoC slice
// word-addressed CSR bus, 32-bit Wishbone classic data path only
package soc_pkg;

	// ----------------------------------------------------------
	// bus structs
	// ----------------------------------------------------------
	typedef struct packed {
		logic [31:0] adr;
		logic [31:0] dat;
		logic [3:0]  sel;
		logic        we;
		logic        cyc;
		logic        stb;
	} wb_req_t;

	typedef struct packed {
		logic [31:0] dat;
		logic        ack;
		logic        err;
	} wb_rsp_t;

	// one CSR access, a is the word address
	typedef struct packed {
		logic [13:0] a;
		logic        we;
		logic [31:0] dw;
	} csr_req_t;

	typedef struct packed {
		logic gpio;
		logic timer;
	} irq_vec_t;

	// ----------------------------------------------------------
	// address map and states
	// ----------------------------------------------------------
	// adr[30:28], bit 31 ignored so 0x8 shadows 0x0
	typedef enum logic [2:0] {
		REGION_RAM = 3'd0,
		REGION_CSR = 3'd6
	} region_e;

	typedef enum logic [1:0] {
		BR_IDLE,
		BR_ACCESS,
		BR_RESPOND
	} bridge_state_e;

	// bank number sits in csr a[13:10]
	localparam logic [3:0] CSR_BANK_SYSCTL = 4'd1;
	localparam logic [3:0] CSR_BANK_TIMER  = 4'd2;

	// register index within a bank, csr a[9:0]
	localparam logic [9:0] SYSCTL_REG_GPIO_IN   = 10'd0;
	localparam logic [9:0] SYSCTL_REG_GPIO_OUT  = 10'd1;
	localparam logic [9:0] SYSCTL_REG_IRQ_MASK  = 10'd2;
	localparam logic [9:0] SYSCTL_REG_SYSTEM_ID = 10'd3;
	localparam logic [9:0] SYSCTL_REG_RESET     = 10'd4;
	localparam logic [9:0] TIMER_REG_CONTROL    = 10'd0;
	localparam logic [9:0] TIMER_REG_COMPARE    = 10'd1;
	localparam logic [9:0] TIMER_REG_COUNTER    = 10'd2;

	localparam int GPIO_IN_W  = 32;
	localparam int GPIO_OUT_W = 4;

	// true when the access targets the given bank
	function automatic logic csr_hit(csr_req_t req, logic [3:0] bank);
		return req.a[13:10] == bank;
	endfunction

endpackage
